/* rv_frontend.f */
+incdir+hdl
hdl/rv_frontend_pkg.sv
hdl/fetch_unit.sv
hdl/fetch_buffer.sv
hdl/inst_decode.sv
hdl/core_frontend.sv
tb/frontend_sva.sv
tb/frontend_checker.sv
tb/frontend_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= frontend_tb
FILELIST  ?= rv_frontend.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

/* tb/frontend_tb.sv */
// ============================
// icache model and backend credit model around core_frontend
// credits held back for 20 cycles after reset
// ============================

`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_consts.svh"

module frontend_tb;

  import rv_frontend_pkg::*;

  localparam int NUM_UOPS     = 24;
  localparam int RESET_CYCLES = 8;
  localparam int HOLD_CYCLES  = 20;
  localparam int LIMIT        = RESET_CYCLES + NUM_UOPS * 12;

  logic       clock;
  logic       reset;
  block_t     icache_data;
  logic       icache_data_valid;
  logic       credit_return;
  logic       icache_req;
  addr_t      icache_addr;
  logic       uop_valid;
  addr_t      uop_pc;
  uop_class_t uop_class;
  reg_idx_t   uop_rd;
  logic       uop_rd_valid;
  reg_idx_t   uop_rs1;
  reg_idx_t   uop_rs2;
  imm_t       uop_imm;
  logic       hold;
  int         exp_index;
  int         exp_sel;
  int         error_count;
  logic       done;

  // instruction words with their expected micro-op fields
  inst_t      tab_inst  [NUM_UOPS];
  uop_class_t tab_class [NUM_UOPS];
  reg_idx_t   tab_rd    [NUM_UOPS];
  logic       tab_rdv   [NUM_UOPS];
  reg_idx_t   tab_rs1   [NUM_UOPS];
  reg_idx_t   tab_rs2   [NUM_UOPS];
  imm_t       tab_imm   [NUM_UOPS];

  core_frontend DUT (
    .clock (clock), .reset (reset),
    .icache_data (icache_data), .icache_data_valid (icache_data_valid),
    .credit_return (credit_return),
    .icache_req (icache_req), .icache_addr (icache_addr),
    .uop_valid (uop_valid), .uop_pc (uop_pc), .uop_class (uop_class),
    .uop_rd (uop_rd), .uop_rd_valid (uop_rd_valid),
    .uop_rs1 (uop_rs1), .uop_rs2 (uop_rs2), .uop_imm (uop_imm)
  );

  assign exp_sel = (exp_index < NUM_UOPS) ? exp_index : 0;

  frontend_checker #(.NUM_UOPS(NUM_UOPS)) u_checker (
    .clock (clock), .reset (reset),
    .icache_req (icache_req), .icache_addr (icache_addr),
    .uop_valid (uop_valid), .uop_pc (uop_pc), .uop_class (uop_class),
    .uop_rd (uop_rd), .uop_rd_valid (uop_rd_valid),
    .uop_rs1 (uop_rs1), .uop_rs2 (uop_rs2), .uop_imm (uop_imm),
    .credit_return (credit_return), .hold (hold),
    .exp_class (tab_class[exp_sel]), .exp_rd (tab_rd[exp_sel]),
    .exp_rd_valid (tab_rdv[exp_sel]), .exp_rs1 (tab_rs1[exp_sel]),
    .exp_rs2 (tab_rs2[exp_sel]), .exp_imm (tab_imm[exp_sel]),
    .index (exp_index), .error_count (error_count), .done (done)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic load_entry(input int i, input inst_t inst, input uop_class_t cls,
                            input reg_idx_t rd, input logic rdv, input reg_idx_t rs1,
                            input reg_idx_t rs2, input imm_t imm);
    tab_inst[i]  = inst;
    tab_class[i] = cls;
    tab_rd[i]    = rd;
    tab_rdv[i]   = rdv;
    tab_rs1[i]   = rs1;
    tab_rs2[i]   = rs2;
    tab_imm[i]   = imm;
  endtask

  initial begin : main
    int cycles;
    void'($urandom(32'h68ff));
    reset = 1'b1;
    // addi, add, sub, addi -1, lui, auipc, lw, sw
    load_entry(0, 32'h00500093, `UOP_CLASS_INT, 1, 1, 0, 5, 32'h5);
    load_entry(1, 32'h002081b3, `UOP_CLASS_INT, 3, 1, 1, 2, 32'h0);
    load_entry(2, 32'h40118233, `UOP_CLASS_INT, 4, 1, 3, 1, 32'h0);
    load_entry(3, 32'hfff08293, `UOP_CLASS_INT, 5, 1, 1, 31, 32'hffffffff);
    load_entry(4, 32'h12345337, `UOP_CLASS_INT, 6, 1, 8, 3, 32'h12345000);
    load_entry(5, 32'hfffff397, `UOP_CLASS_INT, 7, 1, 31, 31, 32'hfffff000);
    load_entry(6, 32'h00812403, `UOP_CLASS_MEM, 8, 1, 2, 8, 32'h8);
    load_entry(7, 32'hfe812e23, `UOP_CLASS_MEM, 28, 0, 2, 8, 32'hfffffffc);
    // beq, bne, jal, j -4, ret, illegal, nop, lb
    load_entry(8, 32'h00208863, `UOP_CLASS_INT, 16, 0, 1, 2, 32'h10);
    load_entry(9, 32'hfe019ce3, `UOP_CLASS_INT, 25, 0, 3, 0, 32'hfffffff8);
    load_entry(10, 32'h001000ef, `UOP_CLASS_INT, 1, 1, 0, 1, 32'h800);
    load_entry(11, 32'hffdff06f, `UOP_CLASS_INT, 0, 0, 31, 29, 32'hfffffffc);
    load_entry(12, 32'h00008067, `UOP_CLASS_INT, 0, 0, 1, 0, 32'h0);
    load_entry(13, 32'hffffffff, `UOP_CLASS_ILLEGAL, 31, 0, 31, 31, 32'h0);
    load_entry(14, 32'h00000013, `UOP_CLASS_INT, 0, 0, 0, 0, 32'h0);
    load_entry(15, 32'hfff58503, `UOP_CLASS_MEM, 10, 1, 11, 31, 32'hffffffff);
    // andi, sb, or, blt with the most negative offset
    load_entry(16, 32'h7ff6f613, `UOP_CLASS_INT, 12, 1, 13, 31, 32'h7ff);
    load_entry(17, 32'h7ee78fa3, `UOP_CLASS_MEM, 31, 0, 15, 14, 32'h7ff);
    load_entry(18, 32'h0128e833, `UOP_CLASS_INT, 16, 1, 17, 18, 32'h0);
    load_entry(19, 32'h8062c063, `UOP_CLASS_INT, 0, 0, 5, 6, 32'hfffff000);
    // lui, jalr, custom-0 opcode, sw x0
    load_entry(20, 32'h80000fb7, `UOP_CLASS_INT, 31, 1, 0, 0, 32'h80000000);
    load_entry(21, 32'h00c100e7, `UOP_CLASS_INT, 1, 1, 2, 12, 32'hc);
    load_entry(22, 32'h0000028b, `UOP_CLASS_ILLEGAL, 5, 0, 0, 0, 32'h0);
    load_entry(23, 32'h00002023, `UOP_CLASS_MEM, 0, 0, 0, 0, 32'h0);

    repeat (RESET_CYCLES) @(posedge clock);
    #1 reset = 1'b0;
    cycles = RESET_CYCLES;
    while (!done && cycles < LIMIT) begin
      @(posedge clock);
      cycles++;
    end

    if (!done) begin
      $display("timeout after %0d cycles with %0d of %0d micro-ops received",
               cycles, exp_index, NUM_UOPS);
      $display("*** FAILED ***");
    end else begin
      // room for any extra micro-op to show up
      repeat (10) @(posedge clock);
      $display("%0d micro-ops checked, %0d errors", exp_index, error_count);
      if (error_count == 0) begin
        $display("*** PASSED ***");
      end else begin
        $display("*** FAILED ***");
      end
    end
    $finish;
  end

  // answers after 1 to 6 cycles, addresses past the table get no answer
  initial begin : icache_model
    int delay;
    int base;
    icache_data       = '0;
    icache_data_valid = 1'b0;
    forever begin
      @(posedge clock);
      #1;
      icache_data_valid = 1'b0;
      if (!reset && icache_req) begin
        base  = int'((icache_addr - `RESET_PC) >> 2);
        delay = $urandom_range(6, 1);
        if (base < NUM_UOPS) begin
          repeat (delay) @(posedge clock);
          #1;
          for (int k = 0; k < `FETCH_WIDTH; k++) begin
            icache_data[k*32 +: 32] = (base + k < NUM_UOPS) ? tab_inst[base + k] : '0;
          end
          icache_data_valid = 1'b1;
        end
      end
    end
  end

  // each micro-op gives its credit back 0 to 5 cycles later, one per cycle
  initial begin : credit_driver
    int due[$];
    int cycle;
    cycle         = 0;
    hold          = 1'b1;
    credit_return = 1'b0;
    forever begin
      @(posedge clock);
      #1;
      cycle++;
      hold = (cycle <= RESET_CYCLES + HOLD_CYCLES);
      if (uop_valid) begin
        due.push_back(cycle + $urandom_range(5, 0));
      end
      credit_return = 1'b0;
      if (!hold && due.size() > 0 && due[0] <= cycle) begin
        void'(due.pop_front());
        credit_return = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* tb/frontend_checker.sv */
// ============================
// samples the DUT on the falling edge
// expected fields come from the tb table by index
// ============================

`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_consts.svh"

module frontend_checker #(
  parameter int NUM_UOPS = 24
) (
  input  wire                            clock,
  input  wire                            reset,
  input  wire                            icache_req,
  input  wire rv_frontend_pkg::addr_t    icache_addr,
  input  wire                            uop_valid,
  input  wire rv_frontend_pkg::addr_t    uop_pc,
  input  wire rv_frontend_pkg::uop_class_t uop_class,
  input  wire rv_frontend_pkg::reg_idx_t uop_rd,
  input  wire                            uop_rd_valid,
  input  wire rv_frontend_pkg::reg_idx_t uop_rs1,
  input  wire rv_frontend_pkg::reg_idx_t uop_rs2,
  input  wire rv_frontend_pkg::imm_t     uop_imm,
  input  wire                            credit_return,
  input  wire                            hold,
  input  wire rv_frontend_pkg::uop_class_t exp_class,
  input  wire rv_frontend_pkg::reg_idx_t exp_rd,
  input  wire                            exp_rd_valid,
  input  wire rv_frontend_pkg::reg_idx_t exp_rs1,
  input  wire rv_frontend_pkg::reg_idx_t exp_rs2,
  input  wire rv_frontend_pkg::imm_t     exp_imm,
  output int                             index,
  output int                             error_count,
  output logic                           done
);

  import rv_frontend_pkg::*;

  int   requests;
  int   in_use;
  int   hold_uops;
  logic hold_seen;
  bit   ok;

  function automatic bit field_ok(string name, logic [31:0] exp, logic [31:0] got);
    if (exp !== got) begin
      $display("CHECK FAILED %s exp=%h got=%h (uop %0d)", name, exp, got, index);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  assign done = (index >= NUM_UOPS);

  always @(negedge clock) begin
    if (reset) begin
      index       = 0;
      error_count = 0;
      requests    = 0;
      in_use      = 0;
      hold_uops   = 0;
      hold_seen   = hold;
    end else begin
      if (icache_req) begin
        if (!field_ok("icache_addr", `RESET_PC + 32'(16 * requests), icache_addr)) begin
          error_count++;
        end
        requests++;
      end

      if (uop_valid) begin
        if (index >= NUM_UOPS) begin
          $display("unexpected micro-op at pc %h after the last table entry", uop_pc);
          error_count++;
        end else begin
          ok = 1'b1;
          ok &= field_ok("uop_pc", `RESET_PC + 32'(4 * index), uop_pc);
          ok &= field_ok("uop_class", 32'(exp_class), 32'(uop_class));
          ok &= field_ok("uop_rd", 32'(exp_rd), 32'(uop_rd));
          ok &= field_ok("uop_rd_valid", 32'(exp_rd_valid), 32'(uop_rd_valid));
          ok &= field_ok("uop_rs1", 32'(exp_rs1), 32'(uop_rs1));
          ok &= field_ok("uop_rs2", 32'(exp_rs2), 32'(uop_rs2));
          ok &= field_ok("uop_imm", exp_imm, uop_imm);
          if (ok) begin
            $display("uop %0d pc %h passed", index, uop_pc);
          end else begin
            $display("uop %0d pc %h failed", index, uop_pc);
            error_count++;
          end
          index++;
        end
      end

      // backend side view of the credits
      in_use = in_use + int'(uop_valid) - int'(credit_return);
      if (in_use > `UOP_CREDITS) begin
        $display("backend holds %0d credits, more than the %0d granted",
                 in_use, `UOP_CREDITS);
        error_count++;
      end

      if (hold && uop_valid) begin
        hold_uops++;
      end
      if (hold_seen && !hold) begin
        if (!field_ok("uops_during_hold", `UOP_CREDITS, hold_uops)) begin
          error_count++;
        end
      end
      hold_seen = hold;
    end
  end

endmodule

`default_nettype wire

/* tb/frontend_sva.sv */
// ============================
// protocol assertions on core_frontend
// icache request rule, credit rule, quiet outputs after reset
// ============================

`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_consts.svh"

module frontend_sva (
  input wire clock,
  input wire reset,
  input wire icache_req,
  input wire icache_data_valid,
  input wire uop_valid,
  input wire credit_return
);

  int   in_use;
  logic req_pending;

  // credits held by the backend, and the request in flight
  always_ff @(posedge clock) begin
    if (reset) begin
      in_use      <= 0;
      req_pending <= 1'b0;
    end else begin
      in_use <= in_use + int'(uop_valid) - int'(credit_return);
      if (icache_req) begin
        req_pending <= 1'b1;
      end else if (icache_data_valid) begin
        req_pending <= 1'b0;
      end
    end
  end

  a_one_request: assert property (@(posedge clock) disable iff (reset)
    icache_req |-> !req_pending)
    else $error("icache_req while a request is still outstanding");

  // a return in the previous cycle was not yet seen by the decoder
  a_credit: assert property (@(posedge clock) disable iff (reset)
    uop_valid |-> (in_use + int'($past(credit_return))) < `UOP_CREDITS)
    else $error("uop_valid without a credit");

  a_reset_quiet: assert property (@(posedge clock)
    $fell(reset) |-> (!icache_req && !uop_valid))
    else $error("outputs active in the first cycle after reset");

endmodule

bind core_frontend frontend_sva u_sva (
  .clock             (clock),
  .reset             (reset),
  .icache_req        (icache_req),
  .icache_data_valid (icache_data_valid),
  .uop_valid         (uop_valid),
  .credit_return     (credit_return)
);

`default_nettype wire

/* hdl/core_frontend.sv */
// ============================
// IF, FB and ID of the core front end
// no branch redirect, no flush
// ============================

`timescale 1ns/1ps
`default_nettype none

module core_frontend (
  input  wire                            clock,
  input  wire                            reset,
  input  wire rv_frontend_pkg::block_t   icache_data,
  input  wire                            icache_data_valid,
  input  wire                            credit_return,
  output logic                           icache_req,
  output rv_frontend_pkg::addr_t         icache_addr,
  output logic                           uop_valid,
  output rv_frontend_pkg::addr_t         uop_pc,
  output rv_frontend_pkg::uop_class_t    uop_class,
  output rv_frontend_pkg::reg_idx_t      uop_rd,
  output logic                           uop_rd_valid,
  output rv_frontend_pkg::reg_idx_t      uop_rs1,
  output rv_frontend_pkg::reg_idx_t      uop_rs2,
  output rv_frontend_pkg::imm_t          uop_imm
);

  import rv_frontend_pkg::*;

  block_t    block;
  logic      block_valid;
  addr_t     block_pc;
  fb_count_t free_count;
  inst_t     head_inst;
  addr_t     head_pc;
  logic      head_valid;
  logic      pop;

  fetch_unit u_fetch (
    .clock             (clock),
    .reset             (reset),
    .icache_data       (icache_data),
    .icache_data_valid (icache_data_valid),
    .free_count        (free_count),
    .icache_req        (icache_req),
    .icache_addr       (icache_addr),
    .block             (block),
    .block_valid       (block_valid),
    .block_pc          (block_pc)
  );

  fetch_buffer u_buffer (
    .clock       (clock),
    .reset       (reset),
    .block       (block),
    .block_valid (block_valid),
    .block_pc    (block_pc),
    .pop         (pop),
    .head_inst   (head_inst),
    .head_pc     (head_pc),
    .head_valid  (head_valid),
    .free_count  (free_count)
  );

  inst_decode u_decode (
    .clock         (clock),
    .reset         (reset),
    .head_inst     (head_inst),
    .head_pc       (head_pc),
    .head_valid    (head_valid),
    .credit_return (credit_return),
    .pop           (pop),
    .uop_valid     (uop_valid),
    .uop_pc        (uop_pc),
    .uop_class     (uop_class),
    .uop_rd        (uop_rd),
    .uop_rd_valid  (uop_rd_valid),
    .uop_rs1       (uop_rs1),
    .uop_rs2       (uop_rs2),
    .uop_imm       (uop_imm)
  );

endmodule

`default_nettype wire

/* hdl/inst_decode.sv */
// ============================
// one RV32I instruction per cycle into a micro-op
// backend grants UOP_CREDITS at reset, one back per credit_return
// backend accepts every uop_valid pulse
// ============================

`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_consts.svh"

module inst_decode (
  input  wire                            clock,
  input  wire                            reset,
  input  wire rv_frontend_pkg::inst_t    head_inst,
  input  wire rv_frontend_pkg::addr_t    head_pc,
  input  wire                            head_valid,
  input  wire                            credit_return,
  output logic                           pop,
  output logic                           uop_valid,
  output rv_frontend_pkg::addr_t         uop_pc,
  output rv_frontend_pkg::uop_class_t    uop_class,
  output rv_frontend_pkg::reg_idx_t      uop_rd,
  output logic                           uop_rd_valid,
  output rv_frontend_pkg::reg_idx_t      uop_rs1,
  output rv_frontend_pkg::reg_idx_t      uop_rs2,
  output rv_frontend_pkg::imm_t          uop_imm
);

  import rv_frontend_pkg::*;

  credit_t    credits;
  logic [6:0] opcode;
  reg_idx_t   rd;
  imm_t       imm_i;
  imm_t       imm_s;
  imm_t       imm_b;
  imm_t       imm_u;
  imm_t       imm_j;
  uop_class_t dec_class;
  imm_t       dec_imm;
  logic       dec_writes;

  assign opcode = head_inst[6:0];
  assign rd     = head_inst[11:7];

  // take the head only when the backend has room
  assign pop = head_valid && (credits != '0);

  assign imm_i = {{20{head_inst[31]}}, head_inst[31:20]};
  assign imm_s = {{20{head_inst[31]}}, head_inst[31:25], head_inst[11:7]};
  assign imm_b = {{19{head_inst[31]}}, head_inst[31], head_inst[7],
                  head_inst[30:25], head_inst[11:8], 1'b0};
  assign imm_u = {head_inst[31:12], 12'b0};
  assign imm_j = {{11{head_inst[31]}}, head_inst[31], head_inst[19:12],
                  head_inst[20], head_inst[30:21], 1'b0};

  always_comb begin
    dec_class  = `UOP_CLASS_ILLEGAL;
    dec_imm    = '0;
    dec_writes = 1'b0;
    case (opcode)
      `OPC_OP: begin
        dec_class  = `UOP_CLASS_INT;
        dec_writes = 1'b1;
      end
      `OPC_OP_IMM, `OPC_JALR: begin
        dec_class  = `UOP_CLASS_INT;
        dec_imm    = imm_i;
        dec_writes = 1'b1;
      end
      `OPC_LUI, `OPC_AUIPC: begin
        dec_class  = `UOP_CLASS_INT;
        dec_imm    = imm_u;
        dec_writes = 1'b1;
      end
      `OPC_JAL: begin
        dec_class  = `UOP_CLASS_INT;
        dec_imm    = imm_j;
        dec_writes = 1'b1;
      end
      // branches read only
      `OPC_BRANCH: begin
        dec_class = `UOP_CLASS_INT;
        dec_imm   = imm_b;
      end
      `OPC_LOAD: begin
        dec_class  = `UOP_CLASS_MEM;
        dec_imm    = imm_i;
        dec_writes = 1'b1;
      end
      `OPC_STORE: begin
        dec_class = `UOP_CLASS_MEM;
        dec_imm   = imm_s;
      end
      default: dec_class = `UOP_CLASS_ILLEGAL;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      credits   <= credit_t'(`UOP_CREDITS);
      uop_valid <= 1'b0;
    end else begin
      credits   <= credits - credit_t'(pop) + credit_t'(credit_return);
      uop_valid <= pop;
    end
  end

  always_ff @(posedge clock) begin
    if (pop) begin
      uop_pc       <= head_pc;
      uop_class    <= dec_class;
      uop_rd       <= rd;
      uop_rd_valid <= dec_writes && (rd != '0);
      uop_rs1      <= head_inst[19:15];
      uop_rs2      <= head_inst[24:20];
      uop_imm      <= dec_imm;
    end
  end

endmodule

`default_nettype wire

/* hdl/fetch_buffer.sv */
// ============================
// ring of FB_DEPTH instructions, FETCH_WIDTH in, one out
// writer must leave room for a whole block, no overflow check
// pop is only legal while head_valid is high
// ============================

`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_consts.svh"

module fetch_buffer (
  input  wire                            clock,
  input  wire                            reset,
  input  wire rv_frontend_pkg::block_t   block,
  input  wire                            block_valid,
  input  wire rv_frontend_pkg::addr_t    block_pc,
  input  wire                            pop,
  output rv_frontend_pkg::inst_t         head_inst,
  output rv_frontend_pkg::addr_t         head_pc,
  output logic                           head_valid,
  output rv_frontend_pkg::fb_count_t     free_count
);

  import rv_frontend_pkg::*;

  localparam int PTR_W = $clog2(`FB_DEPTH);

  inst_t            inst_mem [`FB_DEPTH];
  addr_t            pc_mem   [`FB_DEPTH];
  logic [PTR_W-1:0] head_ptr;
  logic [PTR_W-1:0] tail_ptr;
  fb_count_t        count;
  fb_count_t        count_in;

  assign count_in = block_valid ? fb_count_t'(`FETCH_WIDTH) : '0;

  // whole block lands in one cycle, slot index wraps with the pointer width
  always_ff @(posedge clock) begin
    if (block_valid) begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
        inst_mem[tail_ptr + PTR_W'(i)] <= block[i*`XLEN +: `XLEN];
        pc_mem[tail_ptr + PTR_W'(i)]   <= block_pc + addr_t'(4 * i);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      if (block_valid) begin
        tail_ptr <= tail_ptr + PTR_W'(`FETCH_WIDTH);
      end
      if (pop) begin
        head_ptr <= head_ptr + 1'b1;
      end
      count <= count + count_in - fb_count_t'(pop);
    end
  end

  assign head_inst  = inst_mem[head_ptr];
  assign head_pc    = pc_mem[head_ptr];
  assign head_valid = (count != '0);

  // registered occupancy, a write shows up the cycle after block_valid
  assign free_count = fb_count_t'(`FB_DEPTH) - count;

endmodule

`default_nettype wire

/* hdl/fetch_unit.sv */
// ============================
// one icache request in flight at a time
// requests only with FETCH_WIDTH free buffer slots
// no redirection, pc only moves forward by one block
// ============================

`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_consts.svh"

module fetch_unit (
  input  wire                            clock,
  input  wire                            reset,
  input  wire rv_frontend_pkg::block_t   icache_data,
  input  wire                            icache_data_valid,
  input  wire rv_frontend_pkg::fb_count_t free_count,
  output logic                           icache_req,
  output rv_frontend_pkg::addr_t         icache_addr,
  output rv_frontend_pkg::block_t        block,
  output logic                           block_valid,
  output rv_frontend_pkg::addr_t         block_pc
);

  import rv_frontend_pkg::*;

  localparam int BLOCK_BYTES = `FETCH_WIDTH * 4;

  fetch_state_t state;
  addr_t        pc;
  logic         can_fetch;

  // a block still on its way into the buffer is not in free_count yet
  assign can_fetch = !block_valid && (free_count >= fb_count_t'(`FETCH_WIDTH));

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= FETCH_IDLE;
      pc          <= `RESET_PC;
      icache_req  <= 1'b0;
      block_valid <= 1'b0;
    end else begin
      icache_req  <= 1'b0;
      block_valid <= 1'b0;
      case (state)
        FETCH_IDLE: begin
          if (can_fetch) begin
            icache_req <= 1'b1;
            state      <= FETCH_WAIT;
          end
        end
        FETCH_WAIT: begin
          if (icache_data_valid) begin
            block_valid <= 1'b1;
            pc          <= pc + addr_t'(BLOCK_BYTES);
            state       <= FETCH_IDLE;
          end
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == FETCH_IDLE && can_fetch) begin
      icache_addr <= pc & ~addr_t'(BLOCK_BYTES - 1);
    end
    // capture the response with the address it was fetched from
    if (state == FETCH_WAIT && icache_data_valid) begin
      block    <= icache_data;
      block_pc <= icache_addr;
    end
  end

endmodule

`default_nettype wire

/* hdl/rv_frontend_pkg.sv */
// ============================
// shared front end types
// widths follow rv_frontend_consts.svh
// ============================

`default_nettype none

`include "rv_frontend_consts.svh"

package rv_frontend_pkg;

  typedef logic [`XLEN-1:0] addr_t;
  typedef logic [`XLEN-1:0] inst_t;

  // one icache block, instruction k in bits 32k+31:32k
  typedef logic [`FETCH_WIDTH*`XLEN-1:0] block_t;

  typedef logic [4:0]       reg_idx_t;
  typedef logic [`XLEN-1:0] imm_t;
  typedef logic [1:0]       uop_class_t;

  // must hold 0 up to FB_DEPTH inclusive
  typedef logic [$clog2(`FB_DEPTH+1)-1:0] fb_count_t;

  // 0 up to UOP_CREDITS inclusive
  typedef logic [$clog2(`UOP_CREDITS+1)-1:0] credit_t;

  typedef enum logic {
    FETCH_IDLE,
    FETCH_WAIT
  } fetch_state_t;

endpackage

`default_nettype wire

/* hdl/rv_frontend_consts.svh */
// ============================
// widths, depths and RV32I encodings for the front end
// FB_DEPTH must be a power of two, at least 2 * FETCH_WIDTH
// ============================

`ifndef RV_FRONTEND_CONSTS_SVH
`define RV_FRONTEND_CONSTS_SVH

`define XLEN        32
`define FETCH_WIDTH 4
`define FB_DEPTH    8
`define RESET_PC    32'h8000_0000
`define UOP_CREDITS 4

// RV32I major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111

`define UOP_CLASS_INT     2'd1
`define UOP_CLASS_MEM     2'd2
`define UOP_CLASS_ILLEGAL 2'd3

`endif
